//--- ramio_pkg.sv
// shared types, access codes and i/o addresses for the memory-mapped i/o bridge
// every other file refers to these by scoped name, ramio_pkg::name
`default_nettype none

package ramio_pkg;

  // client side vectors
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0] byte_t;
  typedef logic [3:0] byte_en_t;

  // bit 2 flags sign extension, low bits give the access size
  typedef logic [2:0] read_type_t;
  typedef logic [1:0] write_type_t;

  // access size codes, shared by write_type and read_type[1:0]
  localparam write_type_t SizeNone = 2'b00;
  localparam write_type_t SizeByte = 2'b01;
  localparam write_type_t SizeHalf = 2'b10;
  localparam write_type_t SizeWord = 2'b11;

  // i/o register map at the top of the address space
  localparam addr_t AddrLed = 32'hffff_fffc;
  localparam addr_t AddrUartOut = 32'hffff_fff8;
  localparam addr_t AddrUartIn = 32'hffff_fff4;

  // uart state machines
  typedef enum logic [1:0] {TxIdle, TxStart, TxData, TxStop} tx_state_t;
  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rx_state_t;

endpackage

`default_nettype wire

//--- word_ram.sv
// on-chip word ram with per-byte write enables and one-cycle read latency
// a request is taken when ram_en is high and nothing is pending
// ram_ready pulses exactly one cycle after the accepting edge
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
  parameter int unsigned RamAddressBitWidth = 10
) (
  input wire clk,
  input wire rst_n,
  input wire ram_en,
  input wire [RamAddressBitWidth-1:0] ram_addr,
  input wire ramio_pkg::data_t ram_wdata,
  input wire ramio_pkg::byte_en_t ram_be,
  output ramio_pkg::data_t ram_rdata,
  output logic ram_ready,
  output logic ram_busy
);

  localparam int unsigned Depth = 2 ** RamAddressBitWidth;

  ramio_pkg::data_t mem[Depth];
  logic pending;
  logic accept;

  // one access in flight, a held request is not taken twice
  assign accept = ram_en && !pending;

  // write enabled bytes and register the old word in the same edge
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < $bits(ramio_pkg::byte_en_t); i++) begin
        if (ram_be[i]) begin
          mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
        end
      end
      ram_rdata <= mem[ram_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else begin
      pending <= accept;
    end
  end

  // pending cycle is both the ready pulse and the busy window
  assign ram_ready = pending;
  assign ram_busy = pending;

endmodule

`default_nettype wire

//--- baud_timer.sv
// bit-period timer shared by the uart transmitter and receiver
// restart reloads a full or half period, run lets it count and tick
`timescale 1ns/1ps
`default_nettype none

module baud_timer #(
  parameter int unsigned ClocksPerBit = 8
) (
  input wire clk,
  input wire rst_n,
  input wire run,
  input wire restart,
  input wire half,
  output logic tick
);

  localparam int unsigned CountWidth = $clog2(ClocksPerBit + 1);
  localparam logic [CountWidth-1:0] FullReload = CountWidth'(ClocksPerBit - 1);
  localparam logic [CountWidth-1:0] HalfReload = CountWidth'(ClocksPerBit / 2 - 1);

  logic [CountWidth-1:0] count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
      tick <= 1'b0;
    end else begin
      tick <= 1'b0;
      if (restart) begin
        // half period lands the first tick in the middle of a start bit
        count <= half ? HalfReload : FullReload;
      end else if (run) begin
        if (count == '0) begin
          tick <= 1'b1;
          count <= FullReload;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- uart_tx.sv
// uart transmitter, 8 data bits lsb first, one stop bit, no parity
// a rising tx_go in idle latches tx_data and starts the frame
// tx_busy stays high until the stop bit has been sent
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input wire clk,
  input wire rst_n,
  input wire tx_go,
  input wire ramio_pkg::byte_t tx_data,
  output logic tx_busy,
  input wire tick,
  output logic restart,
  output logic run,
  output logic uart_tx
);

  ramio_pkg::tx_state_t state;
  ramio_pkg::byte_t shift;
  logic [2:0] bit_cnt;
  logic go_q;

  // tx_go is held high across the whole frame, so start on its rising edge only
  assign restart = (state == ramio_pkg::TxIdle) && tx_go && !go_q;
  assign run = (state != ramio_pkg::TxIdle);
  assign tx_busy = (state != ramio_pkg::TxIdle);

  // frame payload, bit 0 is always the next bit on the line
  always_ff @(posedge clk) begin
    if (restart) begin
      shift <= tx_data;
    end else if (tick && (state == ramio_pkg::TxStart || state == ramio_pkg::TxData)) begin
      shift <= shift >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ramio_pkg::TxIdle;
      bit_cnt <= '0;
      go_q <= 1'b0;
      uart_tx <= 1'b1;
    end else begin
      go_q <= tx_go;
      case (state)
        ramio_pkg::TxIdle: begin
          if (restart) begin
            uart_tx <= 1'b0;  // start bit
            state <= ramio_pkg::TxStart;
          end
        end
        ramio_pkg::TxStart: begin
          if (tick) begin
            uart_tx <= shift[0];
            bit_cnt <= '0;
            state <= ramio_pkg::TxData;
          end
        end
        ramio_pkg::TxData: begin
          if (tick) begin
            if (bit_cnt == 3'd7) begin
              uart_tx <= 1'b1;  // stop bit
              state <= ramio_pkg::TxStop;
            end else begin
              uart_tx <= shift[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        ramio_pkg::TxStop: begin
          // line already high, so idle just follows
          if (tick) begin
            state <= ramio_pkg::TxIdle;
          end
        end
        default: state <= ramio_pkg::TxIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- uart_rx.sv
// uart receiver, 8 data bits lsb first, one stop bit, no parity
// samples each bit in its middle using a half-period restart of the baud timer
// rx_valid holds a good byte until rx_ack
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input wire clk,
  input wire rst_n,
  input wire uart_rx,
  input wire rx_ack,
  output logic rx_valid,
  output ramio_pkg::byte_t rx_data,
  input wire tick,
  output logic restart,
  output logic half,
  output logic run
);

  ramio_pkg::rx_state_t state;
  ramio_pkg::byte_t shift;
  logic [2:0] bit_cnt;
  logic rx_meta;
  logic rx_sync;
  logic rx_prev;
  logic frame_ok;

  // falling edge of the line in idle marks a possible start bit
  assign restart = (state == ramio_pkg::RxIdle) && rx_prev && !rx_sync;
  // only the start bit needs the half period
  assign half = (state == ramio_pkg::RxIdle);
  assign run = (state != ramio_pkg::RxIdle);
  assign frame_ok = (state == ramio_pkg::RxStop) && tick && rx_sync;

  // data bits shift in from the top, so lsb ends up in bit 0
  always_ff @(posedge clk) begin
    if (tick && state == ramio_pkg::RxData) begin
      shift <= {rx_sync, shift[7:1]};
    end
    if (frame_ok) begin
      rx_data <= shift;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
      state <= ramio_pkg::RxIdle;
      bit_cnt <= '0;
      rx_valid <= 1'b0;
    end else begin
      // two-stage synchronizer plus one stage for edge detect
      rx_meta <= uart_rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;

      // a new frame wins over an ack in the same cycle
      if (frame_ok) begin
        rx_valid <= 1'b1;
      end else if (rx_ack) begin
        rx_valid <= 1'b0;
      end

      case (state)
        ramio_pkg::RxIdle: begin
          if (restart) begin
            state <= ramio_pkg::RxStart;
          end
        end
        ramio_pkg::RxStart: begin
          if (tick) begin
            // still low at mid-bit, else it was a glitch
            if (!rx_sync) begin
              bit_cnt <= '0;
              state <= ramio_pkg::RxData;
            end else begin
              state <= ramio_pkg::RxIdle;
            end
          end
        end
        ramio_pkg::RxData: begin
          if (tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= ramio_pkg::RxStop;
            end
          end
        end
        ramio_pkg::RxStop: begin
          // bad stop bit drops the frame
          if (tick) begin
            state <= ramio_pkg::RxIdle;
          end
        end
        default: state <= ramio_pkg::RxIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- ramio.sv
// access bridge between a client and the word ram, leds and uart registers
// typed writes become byte-enabled word writes, reads are lane selected and extended
// i/o accesses complete in the same cycle, ram accesses one cycle later
`timescale 1ns/1ps
`default_nettype none

module ramio #(
  parameter int unsigned RamAddressBitWidth = 10
) (
  input wire clk,
  input wire rst_n,
  input wire enable,
  input wire ramio_pkg::read_type_t read_type,
  input wire ramio_pkg::write_type_t write_type,
  input wire ramio_pkg::addr_t address,
  input wire ramio_pkg::data_t data_in,
  output ramio_pkg::data_t data_out,
  output logic data_out_ready,
  output logic busy,
  output logic [3:0] led,
  output logic ram_en,
  output logic [RamAddressBitWidth-1:0] ram_addr,
  output ramio_pkg::data_t ram_wdata,
  output ramio_pkg::byte_en_t ram_be,
  input wire ramio_pkg::data_t ram_rdata,
  input wire ram_ready,
  input wire ram_busy,
  output logic tx_go,
  output ramio_pkg::byte_t tx_data,
  input wire tx_busy,
  input wire rx_valid,
  input wire ramio_pkg::byte_t rx_data,
  output logic rx_ack
);

  logic sel_led;
  logic sel_tx;
  logic sel_rx;
  logic is_io;
  logic is_read;
  logic is_write;
  logic tx_go_prev;
  ramio_pkg::data_t tx_shadow;  // all ones while idle
  ramio_pkg::data_t rx_shadow;  // all ones while empty

  // address decode
  assign sel_led = (address == ramio_pkg::AddrLed);
  assign sel_tx = (address == ramio_pkg::AddrUartOut);
  assign sel_rx = (address == ramio_pkg::AddrUartIn);
  assign is_io = sel_led || sel_tx || sel_rx;
  assign is_read = enable && (read_type != '0);
  assign is_write = enable && (write_type != ramio_pkg::SizeNone);

  // handshake, i/o answers at once, ram forwards its own flags
  assign data_out_ready = enable && (is_io || ram_ready);
  assign busy = enable && !is_io && ram_busy;

  assign ram_en = enable && !is_io;
  assign ram_addr = address[RamAddressBitWidth+1:2];
  assign tx_data = tx_shadow[7:0];

  // write lane steering
  always_comb begin
    ram_be = '0;
    ram_wdata = '0;
    case (write_type)
      ramio_pkg::SizeByte: begin
        ram_be = ramio_pkg::byte_en_t'(4'b0001 << address[1:0]);
        ram_wdata = ramio_pkg::data_t'(data_in[7:0]) << (8 * address[1:0]);
      end
      ramio_pkg::SizeHalf: begin
        // odd half-word address writes nothing
        if (!address[0]) begin
          ram_be = address[1] ? 4'b1100 : 4'b0011;
          ram_wdata = ramio_pkg::data_t'(data_in[15:0]) << (16 * address[1]);
        end
      end
      ramio_pkg::SizeWord: begin
        ram_be = 4'b1111;
        ram_wdata = data_in;
      end
      default: ;
    endcase
  end

  // read lane select and extension
  always_comb begin
    ramio_pkg::byte_t lane_byte;
    logic [15:0] lane_half;
    lane_byte = ram_rdata[8*address[1:0] +: 8];
    lane_half = address[1] ? ram_rdata[31:16] : ram_rdata[15:0];
    data_out = '0;
    if (is_read) begin
      if (sel_led) begin
        data_out = {28'hfff_ffff, led};
      end else if (sel_tx) begin
        data_out = tx_shadow;
      end else if (sel_rx) begin
        data_out = rx_shadow;
      end else begin
        case (read_type[1:0])
          ramio_pkg::SizeByte: begin
            data_out = read_type[2] ? {{24{lane_byte[7]}}, lane_byte} : {24'h0, lane_byte};
          end
          ramio_pkg::SizeHalf: begin
            // misaligned half word reads 0
            if (!address[0]) begin
              data_out = read_type[2] ? {{16{lane_half[15]}}, lane_half} : {16'h0, lane_half};
            end
          end
          ramio_pkg::SizeWord: data_out = ram_rdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led <= 4'b1111;  // active low, all off
      tx_shadow <= '1;
      tx_go <= 1'b0;
      tx_go_prev <= 1'b0;
      rx_shadow <= '1;
      rx_ack <= 1'b0;
    end else begin
      tx_go_prev <= 1'b0;
      rx_ack <= 1'b0;

      if (is_write && sel_led) begin
        led <= data_in[3:0];
      end

      // uart out, hold tx_go until the transmitter reports done
      // tx_busy lags tx_go by a cycle, so skip the first cycle
      if (is_write && sel_tx) begin
        tx_shadow <= {24'h0, data_in[7:0]};
        tx_go <= 1'b1;
        tx_go_prev <= 1'b1;
      end else if (tx_go && !tx_busy && !tx_go_prev) begin
        tx_go <= 1'b0;
        tx_shadow <= '1;
      end

      // uart in, a read empties the register
      // an arriving byte waits a cycle if it collides with the read
      if (is_read && sel_rx) begin
        rx_shadow <= '1;
      end else if (rx_valid && !rx_ack) begin
        rx_shadow <= {24'h0, rx_data};  // overwrites an unread byte
        rx_ack <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- ramio_top.sv
// top level of the i/o bridge, ties the bridge to the word ram and the uart
// ClocksPerBit comes from ClockFrequencyHz and BaudRate and feeds both baud timers
`timescale 1ns/1ps
`default_nettype none

module ramio_top #(
  parameter int unsigned RamAddressBitWidth = 10,
  parameter int unsigned ClockFrequencyHz = 20_250_000,
  parameter int unsigned BaudRate = 115_200
) (
  input wire clk,
  input wire rst_n,
  input wire enable,
  input wire ramio_pkg::read_type_t read_type,
  input wire ramio_pkg::write_type_t write_type,
  input wire ramio_pkg::addr_t address,
  input wire ramio_pkg::data_t data_in,
  output ramio_pkg::data_t data_out,
  output logic data_out_ready,
  output logic busy,
  output logic [3:0] led,
  output logic uart_tx,
  input wire uart_rx
);

  localparam int unsigned ClocksPerBit = ClockFrequencyHz / BaudRate;

  // bridge to ram
  logic ram_en;
  logic [RamAddressBitWidth-1:0] ram_addr;
  ramio_pkg::data_t ram_wdata;
  ramio_pkg::byte_en_t ram_be;
  ramio_pkg::data_t ram_rdata;
  logic ram_ready;
  logic ram_busy;

  // bridge to uart
  logic tx_go;
  ramio_pkg::byte_t tx_data;
  logic tx_busy;
  logic rx_valid;
  ramio_pkg::byte_t rx_data;
  logic rx_ack;

  // uart to baud timers
  logic tx_tick;
  logic tx_restart;
  logic tx_run;
  logic rx_tick;
  logic rx_restart;
  logic rx_half;
  logic rx_run;

  ramio #(
    .RamAddressBitWidth(RamAddressBitWidth)
  ) u_ramio (
    .clk, .rst_n, .enable, .read_type, .write_type, .address, .data_in,
    .data_out, .data_out_ready, .busy, .led,
    .ram_en, .ram_addr, .ram_wdata, .ram_be, .ram_rdata, .ram_ready, .ram_busy,
    .tx_go, .tx_data, .tx_busy, .rx_valid, .rx_data, .rx_ack
  );

  word_ram #(
    .RamAddressBitWidth(RamAddressBitWidth)
  ) u_word_ram (
    .clk, .rst_n, .ram_en, .ram_addr, .ram_wdata, .ram_be,
    .ram_rdata, .ram_ready, .ram_busy
  );

  uart_tx u_uart_tx (
    .clk, .rst_n, .tx_go, .tx_data, .tx_busy,
    .tick(tx_tick), .restart(tx_restart), .run(tx_run), .uart_tx
  );

  uart_rx u_uart_rx (
    .clk, .rst_n, .uart_rx, .rx_ack, .rx_valid, .rx_data,
    .tick(rx_tick), .restart(rx_restart), .half(rx_half), .run(rx_run)
  );

  // transmitter always restarts on a full period
  baud_timer #(
    .ClocksPerBit(ClocksPerBit)
  ) u_tx_baud (
    .clk, .rst_n, .run(tx_run), .restart(tx_restart), .half(1'b0), .tick(tx_tick)
  );

  baud_timer #(
    .ClocksPerBit(ClocksPerBit)
  ) u_rx_baud (
    .clk, .rst_n, .run(rx_run), .restart(rx_restart), .half(rx_half), .tick(rx_tick)
  );

endmodule

`default_nettype wire

//--- tb_ramio_top.sv
// self-checking testbench for the memory-mapped i/o bridge
// drives client accesses against a byte-level model of the ram
// the uart output is looped back to the uart input
`timescale 1ns/1ps
`default_nettype none

module tb_ramio_top;

  localparam int unsigned RamAddressBitWidth = 8;
  localparam int unsigned ClockFrequencyHz = 8_000_000;
  localparam int unsigned BaudRate = 1_000_000;
  // start bit, eight data bits and stop bit
  localparam int unsigned FrameCycles = 10 * (ClockFrequencyHz / BaudRate);
  // cycle or poll limit for every wait loop
  localparam int Timeout = 200;

  logic clk = 1'b0;
  logic rst_n;
  logic enable;
  ramio_pkg::read_type_t read_type;
  ramio_pkg::write_type_t write_type;
  ramio_pkg::addr_t address;
  ramio_pkg::data_t data_in;
  ramio_pkg::data_t data_out;
  logic data_out_ready;
  logic busy;
  logic [3:0] led;
  logic uart_line;

  // byte view of the ram, indexed by byte address
  logic [7:0] mem_model [0:1023];
  logic [31:0] rng_state = 32'd17517;
  int unsigned cycle_count = 0;
  int checks = 0;
  int errors = 0;

  ramio_top #(
    .RamAddressBitWidth(RamAddressBitWidth),
    .ClockFrequencyHz(ClockFrequencyHz),
    .BaudRate(BaudRate)
  ) dut (
    .clk, .rst_n, .enable, .read_type, .write_type, .address, .data_in,
    .data_out, .data_out_ready, .busy, .led,
    .uart_tx(uart_line), .uart_rx(uart_line)
  );

  always #5 clk = ~clk;

  // free-running cycle count for frame timing
  always @(posedge clk) cycle_count <= cycle_count + 1;

  // xorshift32 generator
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // expected read value from the byte model, read_type and address
  function automatic ramio_pkg::data_t expect_read(input ramio_pkg::read_type_t rt,
                                                   input ramio_pkg::addr_t addr);
    logic [9:0] lo;
    logic [7:0] b;
    logic [15:0] h;
    ramio_pkg::data_t result;
    lo = {addr[9:2], addr[1], 1'b0};
    b = mem_model[addr[9:0]];
    h = {mem_model[lo + 10'd1], mem_model[lo]};
    result = '0;
    case (rt[1:0])
      2'b01: result = rt[2] ? {{24{b[7]}}, b} : {24'h0, b};
      2'b10: begin
        // odd address gives 0
        if (!addr[0]) begin
          result = rt[2] ? {{16{h[15]}}, h} : {16'h0, h};
        end
      end
      2'b11: begin
        result = {mem_model[{addr[9:2], 2'd3}], mem_model[{addr[9:2], 2'd2}],
                  mem_model[{addr[9:2], 2'd1}], mem_model[{addr[9:2], 2'd0}]};
      end
      default: result = '0;
    endcase
    return result;
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic update_model(input ramio_pkg::write_type_t wt, input ramio_pkg::addr_t addr,
                              input ramio_pkg::data_t wdata);
    logic [9:0] a;
    a = addr[9:0];
    case (wt)
      ramio_pkg::SizeByte: mem_model[a] = wdata[7:0];
      ramio_pkg::SizeHalf: begin
        // odd address leaves memory untouched
        if (!a[0]) begin
          mem_model[a] = wdata[7:0];
          mem_model[a + 10'd1] = wdata[15:8];
        end
      end
      ramio_pkg::SizeWord: begin
        for (int k = 0; k < 4; k++) begin
          mem_model[{a[9:2], 2'(k)}] = wdata[8*k +: 8];
        end
      end
      default: ;
    endcase
  endtask

  task automatic drive_request(input ramio_pkg::read_type_t rt, input ramio_pkg::write_type_t wt,
                               input ramio_pkg::addr_t addr, input ramio_pkg::data_t wdata);
    enable = 1'b1;
    read_type = rt;
    write_type = wt;
    address = addr;
    data_in = wdata;
  endtask

  task automatic clear_request();
    enable = 1'b0;
    read_type = '0;
    write_type = ramio_pkg::SizeNone;
  endtask

  // ram access, held until data_out_ready is seen
  task automatic ram_access(input ramio_pkg::read_type_t rt, input ramio_pkg::write_type_t wt,
                            input ramio_pkg::addr_t addr, input ramio_pkg::data_t wdata,
                            output ramio_pkg::data_t rdata);
    int cycles;
    @(posedge clk);
    #1;
    drive_request(rt, wt, addr, wdata);
    @(negedge clk);
    compare("data_out_ready", 32'd0, 32'(data_out_ready));
    compare("busy", 32'd0, 32'(busy));
    cycles = 0;
    rdata = '0;
    while (data_out_ready !== 1'b1 && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (data_out_ready === 1'b1) begin
      compare("data_out_ready latency", 32'd1, 32'(cycles));
      compare("busy", 32'd1, 32'(busy));
      rdata = data_out;
    end else begin
      errors++;
      $display("timeout waiting for data_out_ready on a ram access at %0t ns", $time);
    end
    @(posedge clk);
    #1;
    clear_request();
    // handshake outputs drop with enable
    @(negedge clk);
    compare("data_out_ready", 32'd0, 32'(data_out_ready));
    compare("busy", 32'd0, 32'(busy));
  endtask

  // i/o access, one cycle, answered in the same cycle
  task automatic io_access(input ramio_pkg::read_type_t rt, input ramio_pkg::write_type_t wt,
                           input ramio_pkg::addr_t addr, input ramio_pkg::data_t wdata,
                           output ramio_pkg::data_t rdata);
    @(posedge clk);
    #1;
    drive_request(rt, wt, addr, wdata);
    @(negedge clk);
    compare("data_out_ready", 32'd1, 32'(data_out_ready));
    compare("busy", 32'd0, 32'(busy));
    rdata = data_out;
    @(posedge clk);
    #1;
    clear_request();
  endtask

  task automatic write_ram(input ramio_pkg::write_type_t wt, input ramio_pkg::addr_t addr,
                           input ramio_pkg::data_t wdata);
    ramio_pkg::data_t ignored;
    ram_access(3'b000, wt, addr, wdata, ignored);
    update_model(wt, addr, wdata);
  endtask

  task automatic check_ram_read(input ramio_pkg::read_type_t rt, input ramio_pkg::addr_t addr);
    ramio_pkg::data_t got;
    ram_access(rt, ramio_pkg::SizeNone, addr, '0, got);
    compare("data_out", expect_read(rt, addr), got);
  endtask

  // every byte and half-word read type at every lane, plus both word reads
  task automatic check_lanes(input ramio_pkg::addr_t base);
    for (int lane = 0; lane < 4; lane++) begin
      for (int sign = 0; sign < 2; sign++) begin
        check_ram_read({1'(sign), ramio_pkg::SizeByte}, base + ramio_pkg::addr_t'(lane));
        check_ram_read({1'(sign), ramio_pkg::SizeHalf}, base + ramio_pkg::addr_t'(lane));
      end
    end
    check_ram_read({1'b0, ramio_pkg::SizeWord}, base);
    check_ram_read({1'b1, ramio_pkg::SizeWord}, base);
  endtask

  initial begin
    ramio_pkg::addr_t addr_list[16];
    ramio_pkg::addr_t addr;
    ramio_pkg::data_t word;
    ramio_pkg::data_t got;
    int polls;
    int unsigned sent_at;

    rst_n = 1'b0;
    enable = 1'b0;
    read_type = '0;
    write_type = ramio_pkg::SizeNone;
    address = '0;
    data_in = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    compare("led", 32'h0000_000f, {28'h0, led});
    compare("uart_tx", 32'd1, 32'(uart_line));
    compare("data_out_ready", 32'd0, 32'(data_out_ready));
    compare("busy", 32'd0, 32'(busy));

    // random word writes, then word reads
    for (int i = 0; i < 16; i++) begin
      addr_list[i] = next_random() & 32'h0000_03fc;
      write_ram(ramio_pkg::SizeWord, addr_list[i], next_random());
    end
    for (int i = 0; i < 16; i++) begin
      check_ram_read({1'b0, ramio_pkg::SizeWord}, addr_list[i]);
    end

    // byte lanes, then half words including the odd addresses
    for (int n = 0; n < 4; n++) begin
      addr = next_random() & 32'h0000_03fc;
      write_ram(ramio_pkg::SizeWord, addr, next_random());
      for (int lane = 0; lane < 4; lane++) begin
        write_ram(ramio_pkg::SizeByte, addr + ramio_pkg::addr_t'(lane), next_random());
      end
      check_lanes(addr);
      for (int lane = 0; lane < 4; lane++) begin
        write_ram(ramio_pkg::SizeHalf, addr + ramio_pkg::addr_t'(lane), next_random());
      end
      check_lanes(addr);
    end

    // led register, low nibble only, upper bits read as ones
    for (int n = 0; n < 3; n++) begin
      word = next_random();
      io_access(3'b000, ramio_pkg::SizeWord, ramio_pkg::AddrLed, word, got);
      compare("led", {28'h0, word[3:0]}, {28'h0, led});
      io_access(3'b011, ramio_pkg::SizeNone, ramio_pkg::AddrLed, '0, got);
      compare("data_out", {28'hfff_ffff, word[3:0]}, got);
    end

    // idle uart registers
    io_access(3'b011, ramio_pkg::SizeNone, ramio_pkg::AddrUartIn, '0, got);
    compare("data_out", 32'hffff_ffff, got);
    io_access(3'b011, ramio_pkg::SizeNone, ramio_pkg::AddrUartOut, '0, got);
    compare("data_out", 32'hffff_ffff, got);

    // uart loopback
    for (int n = 0; n < 3; n++) begin
      word = next_random();
      io_access(3'b000, ramio_pkg::SizeWord, ramio_pkg::AddrUartOut, word, got);
      sent_at = cycle_count;
      io_access(3'b011, ramio_pkg::SizeNone, ramio_pkg::AddrUartOut, '0, got);
      compare("data_out", {24'h0, word[7:0]}, got);
      // uart out holds the byte until the frame is sent
      polls = 0;
      do begin
        io_access(3'b011, ramio_pkg::SizeNone, ramio_pkg::AddrUartOut, '0, got);
        if (got !== 32'hffff_ffff) begin
          compare("data_out", {24'h0, word[7:0]}, got);
        end
        polls++;
      end while (got !== 32'hffff_ffff && polls < Timeout);
      if (got !== 32'hffff_ffff) begin
        errors++;
        $display("timeout waiting for uart out to return to idle at %0t ns", $time);
      end else if (cycle_count - sent_at < FrameCycles) begin
        // a whole frame has to go out before the register reads idle
        errors++;
        $display("uart out read idle after %0d cycles, before a full frame was sent, at %0t ns",
                 cycle_count - sent_at, $time);
      end
      polls = 0;
      do begin
        io_access(3'b011, ramio_pkg::SizeNone, ramio_pkg::AddrUartIn, '0, got);
        polls++;
      end while (got === 32'hffff_ffff && polls < Timeout);
      if (got === 32'hffff_ffff) begin
        errors++;
        $display("timeout waiting for a received byte at %0t ns", $time);
      end else begin
        compare("data_out", {24'h0, word[7:0]}, got);
      end
      // the read empties the register
      io_access(3'b011, ramio_pkg::SizeNone, ramio_pkg::AddrUartIn, '0, got);
      compare("data_out", 32'hffff_ffff, got);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ramio.f
ramio_pkg.sv
word_ram.sv
baud_timer.sv
uart_tx.sv
uart_rx.sv
ramio.sv
ramio_top.sv
tb_ramio_top.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
verilator --binary --timing -f ramio.f --top-module tb_ramio_top \
  && ./obj_dir/Vtb_ramio_top > sim.log 2>&1 \
  ; cat sim.log \
  && grep -q "All tests passed" sim.log \
  && echo "simulation ok" \
  || { echo "simulation failed, see sim.log"; exit 1; }
